/* project.f */
source/cache_pkg.sv
source/cache_controller.sv
source/cache_datapath.sv
source/mem_interface.sv
source/cache_top.sv
verification/cache_assertions.sv
verification/cache_tb.sv

/* source/cache_controller.sv */
module cache_controller (
    input  logic               clk,
    input  logic               reset,
    input  logic               cpu_valid,
    input  cache_pkg::op_t     op,
    input  cache_pkg::status_t status,
    input  logic               axi_ready,
    output logic               read_req,
    output logic               write_req,
    output cache_pkg::ctrl_t   ctrl,
    output logic               cache_ready,
    output logic               done
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE            = 3'b000,
        PROCESS_REQUEST = 3'b001,
        ALLOCATE_MEMORY = 3'b010,
        WRITEBACK       = 3'b011,
        FLUSH           = 3'b100
    } state_t;

    state_t state;
    state_t next_state;

    // set while a flush walk is in progress
    logic flushing;
    logic flushing_next;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= IDLE;
            flushing <= 1'b0;
        end else begin
            state    <= next_state;
            flushing <= flushing_next;
        end
    end

    always_comb begin
        next_state    = state;
        flushing_next = flushing;
        ctrl          = '0;
        read_req      = 1'b0;
        write_req     = 1'b0;
        cache_ready   = 1'b0;
        done          = 1'b0;

        case (state)
            IDLE: begin
                cache_ready = 1'b1;
                if (cpu_valid) begin
                    ctrl.capture_req = 1'b1;
                    case (op)
                        op_read,
                        op_write: begin
                            next_state = PROCESS_REQUEST;
                        end
                        op_flush: begin
                            flushing_next = 1'b1;
                            next_state    = FLUSH;
                        end
                        default: begin
                            next_state = IDLE;
                        end
                    endcase
                end
            end

            PROCESS_REQUEST: begin
                if (status.cache_hit) begin
                    done = 1'b1;
                    if (status.op == op_write) begin
                        ctrl.write_from_cpu = 1'b1;
                    end else begin
                        ctrl.read_from_cache = 1'b1;
                    end
                    next_state = IDLE;
                end else if (status.cache_miss && status.dirty_bit) begin
                    // victim goes out before the fill
                    write_req          = 1'b1;
                    ctrl.writeback_sel = 1'b1;
                    next_state         = WRITEBACK;
                end else if (status.cache_miss) begin
                    read_req   = 1'b1;
                    next_state = ALLOCATE_MEMORY;
                end
            end

            ALLOCATE_MEMORY: begin
                read_req = 1'b1;
                if (axi_ready) begin
                    ctrl.write_from_main_mem = 1'b1;
                    ctrl.change_dirty_bit    = 1'b1;
                    next_state               = PROCESS_REQUEST;
                end
            end

            WRITEBACK: begin
                write_req          = 1'b1;
                ctrl.writeback_sel = 1'b1;
                // keep the flush index selected during a flush writeback
                ctrl.flush_en      = flushing;
                if (axi_ready) begin
                    if (flushing) begin
                        ctrl.change_dirty_bit = 1'b1;
                        next_state            = FLUSH;
                    end else begin
                        next_state = ALLOCATE_MEMORY;
                    end
                end
            end

            FLUSH: begin
                ctrl.flush_en = 1'b1;
                if (status.dirty_bit) begin
                    write_req          = 1'b1;
                    ctrl.writeback_sel = 1'b1;
                    next_state         = WRITEBACK;
                end else if (status.flush_done) begin
                    flushing_next = 1'b0;
                    next_state    = IDLE;
                end else begin
                    ctrl.flush_count_en = 1'b1;
                end
            end

            default: begin
                flushing_next = 1'b0;
                next_state    = IDLE;
            end
        endcase
    end

endmodule

/* source/cache_datapath.sv */
module cache_datapath (
    input  logic                             clk,
    input  logic                             reset,
    input  cache_pkg::cpu_req_t              cpu_req,
    input  cache_pkg::ctrl_t                 ctrl,
    input  logic [cache_pkg::data_width-1:0] fill_data,
    output cache_pkg::status_t               status,
    output logic [cache_pkg::data_width-1:0] rdata,
    output logic [cache_pkg::addr_width-1:0] line_addr,
    output logic [cache_pkg::data_width-1:0] victim_data
);

    import cache_pkg::*;

    cpu_req_t req_q;

    logic [tag_width-1:0]    tag_mem  [2**index_width];
    logic [data_width-1:0]   data_mem [2**index_width];
    logic [2**index_width-1:0] valid_bits;
    logic [2**index_width-1:0] dirty_bits;

    logic [index_width-1:0] flush_index;
    logic [index_width-1:0] index;
    logic [tag_width-1:0]   req_tag;
    logic                   hit;
    logic [data_width-1:0]  rdata_q;

    assign req_tag = req_q.addr[addr_width-1 -: tag_width];

    // flush walk overrides the request index
    assign index = ctrl.flush_en ? flush_index : req_q.addr[index_width-1:0];

    assign hit = valid_bits[index] && (tag_mem[index] == req_tag);

    assign status.cache_hit  = hit;
    assign status.cache_miss = !hit;
    assign status.dirty_bit  = valid_bits[index] && dirty_bits[index];
    assign status.flush_done = (flush_index == {index_width{1'b1}})
                               && !(valid_bits[flush_index] && dirty_bits[flush_index]);
    assign status.op         = req_q.op;

    // victim address uses the stored tag
    assign line_addr   = ctrl.writeback_sel ? {tag_mem[index], index} : {req_tag, index};
    assign victim_data = data_mem[index];

    assign rdata = ctrl.read_from_cache ? data_mem[index] : rdata_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (ctrl.write_from_main_mem) begin
                valid_bits[index] <= 1'b1;
            end
            if (ctrl.change_dirty_bit) begin
                dirty_bits[index] <= 1'b0;
            end else if (ctrl.write_from_cpu) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flush_index <= '0;
        end else if (!ctrl.flush_en) begin
            flush_index <= '0;
        end else if (ctrl.flush_count_en) begin
            flush_index <= flush_index + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.capture_req) begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.write_from_main_mem) begin
            tag_mem[index]  <= req_tag;
            data_mem[index] <= fill_data;
        end else if (ctrl.write_from_cpu) begin
            data_mem[index] <= req_q.wdata;
        end
    end

    // hold read data after the done pulse
    always_ff @(posedge clk) begin
        if (ctrl.read_from_cache) begin
            rdata_q <= data_mem[index];
        end
    end

endmodule

/* source/cache_pkg.sv */
package cache_pkg;

    // geometry
    localparam int addr_width  = 16;
    localparam int data_width  = 32;
    localparam int index_width = 4;
    localparam int tag_width   = addr_width - index_width;

    typedef enum logic [1:0] {
        op_read  = 2'b00,
        op_write = 2'b01,
        op_flush = 2'b10,
        op_none  = 2'b11
    } op_t;

    typedef struct packed {
        op_t                   op;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  done;
        logic [data_width-1:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    // controller strobes into the datapath
    typedef struct packed {
        logic change_dirty_bit;
        logic read_from_cache;
        logic write_from_cpu;
        logic write_from_main_mem;
        logic flush_en;
        logic flush_count_en;
        logic capture_req;
        logic writeback_sel;
    } ctrl_t;

    typedef struct packed {
        logic cache_hit;
        logic cache_miss;
        logic dirty_bit;
        logic flush_done;
        op_t  op;
    } status_t;

endpackage

/* source/cache_top.sv */
module cache_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cpu_valid,
    input  cache_pkg::cpu_req_t              cpu_req,
    input  logic                             mem_ack,
    input  logic [cache_pkg::data_width-1:0] mem_rdata,
    output logic                             cache_ready,
    output cache_pkg::cpu_resp_t             cpu_resp,
    output cache_pkg::mem_req_t              mem_req
);

    import cache_pkg::*;

    ctrl_t                 ctrl;
    status_t               status;
    logic                  read_req;
    logic                  write_req;
    logic                  axi_ready;
    logic                  done;
    logic [data_width-1:0] rdata;
    logic [data_width-1:0] fill_data;
    logic [data_width-1:0] victim_data;
    logic [addr_width-1:0] line_addr;

    cache_controller controller_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_valid   (cpu_valid),
        .op          (cpu_req.op),
        .status      (status),
        .axi_ready   (axi_ready),
        .read_req    (read_req),
        .write_req   (write_req),
        .ctrl        (ctrl),
        .cache_ready (cache_ready),
        .done        (done)
    );

    cache_datapath datapath_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .ctrl        (ctrl),
        .fill_data   (fill_data),
        .status      (status),
        .rdata       (rdata),
        .line_addr   (line_addr),
        .victim_data (victim_data)
    );

    mem_interface mem_if_i (
        .clk         (clk),
        .reset       (reset),
        .read_req    (read_req),
        .write_req   (write_req),
        .line_addr   (line_addr),
        .victim_data (victim_data),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .axi_ready   (axi_ready),
        .fill_data   (fill_data)
    );

    assign cpu_resp.done  = done;
    assign cpu_resp.rdata = rdata;

endmodule

/* source/mem_interface.sv */
module mem_interface (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             read_req,
    input  logic                             write_req,
    input  logic [cache_pkg::addr_width-1:0] line_addr,
    input  logic [cache_pkg::data_width-1:0] victim_data,
    input  logic                             mem_ack,
    input  logic [cache_pkg::data_width-1:0] mem_rdata,
    output cache_pkg::mem_req_t              mem_req,
    output logic                             axi_ready,
    output logic [cache_pkg::data_width-1:0] fill_data
);

    import cache_pkg::*;

    logic                  rd_q;
    logic                  wr_q;
    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] wdata_q;
    logic                  busy;
    logic                  start;

    assign busy = rd_q || wr_q;

    // request is still high in the cycle after an ack
    assign start = (read_req || write_req) && !busy && !axi_ready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_q      <= 1'b0;
            wr_q      <= 1'b0;
            axi_ready <= 1'b0;
        end else begin
            axi_ready <= busy && mem_ack;
            if (busy && mem_ack) begin
                rd_q <= 1'b0;
                wr_q <= 1'b0;
            end else if (start) begin
                wr_q <= write_req;
                rd_q <= read_req && !write_req;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= line_addr;
            wdata_q <= victim_data;
        end
        if (busy && mem_ack) begin
            fill_data <= mem_rdata;
        end
    end

    assign mem_req.read  = rd_q;
    assign mem_req.write = wr_q;
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = wdata_q;

endmodule

/* verification/cache_assertions.sv */
module cache_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 cache_ready,
    input cache_pkg::cpu_resp_t cpu_resp,
    input cache_pkg::mem_req_t  mem_req
);

    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int error_count = 0;

    property single_strobe;
        @(posedge clk) disable iff (!reset) !(mem_req.read && mem_req.write);
    endproperty

    property busy_while_strobe;
        @(posedge clk) disable iff (!reset) (mem_req.read || mem_req.write) |-> !cache_ready;
    endproperty

    property done_single_cycle;
        @(posedge clk) disable iff (!reset) cpu_resp.done |=> !cpu_resp.done;
    endproperty

    single_strobe_a: assert property (single_strobe) else begin
        error_count++;
        $error("memory read and write strobes high together");
    end

    busy_while_strobe_a: assert property (busy_while_strobe) else begin
        error_count++;
        $error("cache_ready high while a memory strobe is active");
    end

    done_single_cycle_a: assert property (done_single_cycle) else begin
        error_count++;
        $error("done held high for two cycles");
    end

endmodule

bind cache_top cache_assertions assertions_i (
    .clk         (clk),
    .reset       (reset),
    .cache_ready (cache_ready),
    .cpu_resp    (cpu_resp),
    .mem_req     (mem_req)
);

/* verification/cache_tb.sv */
module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    localparam int          clk_period     = 8;
    localparam int          random_ops     = 200;
    // worst case miss with writeback is about 16 cycles
    localparam int          timeout_cycles = random_ops * 16 + 800;
    localparam logic [31:0] lfsr_seed      = 32'h2958_4f8c;

    typedef struct packed {
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } mem_txn_t;

    logic                  clk;
    logic                  reset;
    logic                  cpu_valid;
    cpu_req_t              cpu_req;
    logic                  mem_ack;
    logic [data_width-1:0] mem_rdata;
    logic                  cache_ready;
    cpu_resp_t             cpu_resp;
    mem_req_t              mem_req;

    logic [data_width-1:0] memory [logic [addr_width-1:0]];
    logic [data_width-1:0] shadow [logic [addr_width-1:0]];
    mem_txn_t              mem_log [$];

    // predicted line state
    logic                 line_valid [2**index_width];
    logic                 line_dirty [2**index_width];
    logic [tag_width-1:0] line_tag   [2**index_width];

    logic [31:0] ack_lfsr  = lfsr_seed;
    logic [31:0] stim_lfsr = lfsr_seed;
    string       test_name = "";
    int          failures;
    int          cycle_count;

    cache_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata),
        .cache_ready (cache_ready),
        .cpu_resp    (cpu_resp),
        .mem_req     (mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Test failures found");
        $fatal(1, "simulation stopped by the cycle limit");
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    // untouched memory words
    function automatic logic [data_width-1:0] fill_pattern(input logic [addr_width-1:0] addr);
        return {~addr, addr ^ 16'hc35a};
    endfunction

    function automatic logic [data_width-1:0] mem_value(input logic [addr_width-1:0] addr);
        return memory.exists(addr) ? memory[addr] : fill_pattern(addr);
    endfunction

    function automatic logic [data_width-1:0] shadow_value(input logic [addr_width-1:0] addr);
        return shadow.exists(addr) ? shadow[addr] : fill_pattern(addr);
    endfunction

    // answers each strobe after 0 to 3 wait cycles
    initial begin : memory_model
        logic [31:0] delay_bits;
        int          wait_left;
        logic        pending;

        mem_ack   = 1'b0;
        mem_rdata = '0;
        pending   = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clk);
            if (mem_ack) begin
                mem_ack = 1'b0;
            end else if (mem_req.read || mem_req.write) begin
                if (!pending) begin
                    take_bits(ack_lfsr, 2, delay_bits);
                    wait_left = delay_bits;
                    pending   = 1'b1;
                end
                if (wait_left == 0) begin
                    if (mem_req.write) begin
                        memory[mem_req.addr] = mem_req.wdata;
                        mem_log.push_back(mem_txn_t'({1'b1, mem_req.addr, mem_req.wdata}));
                    end else begin
                        mem_rdata = mem_value(mem_req.addr);
                        mem_log.push_back(mem_txn_t'({1'b0, mem_req.addr, mem_rdata}));
                    end
                    mem_ack = 1'b1;
                    pending = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            failures++;
            $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_traffic(input mem_txn_t expected [$]);
        check("memory transactions", expected.size(), mem_log.size());
        foreach (expected[i]) begin
            check("memory write strobe", expected[i].write, mem_log[i].write);
            check("memory address", expected[i].addr, mem_log[i].addr);
            check("memory data", expected[i].data, mem_log[i].data);
        end
    endtask

    task automatic wait_ready();
        while (!cache_ready) @(negedge clk);
    endtask

    // one read or write with its latency in cycles from acceptance
    task automatic cpu_access(input op_t op, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata, output int latency);
        mem_txn_t               expected [$];
        logic [index_width-1:0] idx;
        logic [tag_width-1:0]   tag;
        logic [addr_width-1:0]  victim;
        logic [data_width-1:0]  expected_rdata;

        idx = addr[index_width-1:0];
        tag = addr[addr_width-1 -: tag_width];
        if (!(line_valid[idx] && line_tag[idx] == tag)) begin
            if (line_valid[idx] && line_dirty[idx]) begin
                victim = {line_tag[idx], idx};
                expected.push_back(mem_txn_t'({1'b1, victim, shadow_value(victim)}));
            end
            expected.push_back(mem_txn_t'({1'b0, addr, shadow_value(addr)}));
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
            line_dirty[idx] = 1'b0;
        end
        expected_rdata = shadow_value(addr);
        if (op == op_write) begin
            shadow[addr]    = wdata;
            line_dirty[idx] = 1'b1;
        end

        mem_log.delete();
        wait_ready();
        cpu_req.op    = op;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_valid     = 1'b1;
        latency       = 0;
        do begin
            @(negedge clk);
            cpu_valid  = 1'b0;
            cpu_req.op = op_none;
            latency++;
        end while (!cpu_resp.done);

        if (op == op_read) begin
            check("read data", expected_rdata, cpu_resp.rdata);
        end
        compare_traffic(expected);
    endtask

    task automatic cpu_flush();
        mem_txn_t              expected [$];
        logic [addr_width-1:0] victim;
        logic                  saw_done;

        for (int i = 0; i < 2**index_width; i++) begin
            if (line_valid[i] && line_dirty[i]) begin
                victim = {line_tag[i], index_width'(i)};
                expected.push_back(mem_txn_t'({1'b1, victim, shadow_value(victim)}));
                line_dirty[i] = 1'b0;
            end
        end

        mem_log.delete();
        saw_done = 1'b0;
        wait_ready();
        cpu_req.op = op_flush;
        cpu_valid  = 1'b1;
        @(negedge clk);
        cpu_valid  = 1'b0;
        cpu_req.op = op_none;
        while (!cache_ready) begin
            if (cpu_resp.done) begin
                saw_done = 1'b1;
            end
            @(negedge clk);
        end
        check("done pulse during flush", 1'b0, saw_done);
        compare_traffic(expected);
    endtask

    task automatic expect_reset_state();
        test_name = "reset state";
        check("cache_ready", 1'b1, cache_ready);
        check("done", 1'b0, cpu_resp.done);
        check("memory read strobe", 1'b0, mem_req.read);
        check("memory write strobe", 1'b0, mem_req.write);
    endtask

    task automatic read_miss_then_hit();
        logic [addr_width-1:0] addr;
        int                    latency;

        test_name = "read miss then hit";
        addr      = 16'h0123;
        cpu_access(op_read, addr, '0, latency);
        check("fill reads", 1, mem_log.size());
        check("fill address", addr, mem_log[0].addr);
        check("memory value returned", mem_value(addr), cpu_resp.rdata);
        cpu_access(op_read, addr, '0, latency);
        check("hit latency", 1, latency);
        check("hit memory traffic", 0, mem_log.size());
    endtask

    task automatic evict_dirty_line();
        logic [addr_width-1:0] old_addr;
        logic [addr_width-1:0] new_addr;
        int                    latency;

        test_name = "write hit and dirty eviction";
        old_addr  = 16'h0235;
        new_addr  = 16'h0a35;
        cpu_access(op_read, old_addr, '0, latency);
        cpu_access(op_write, old_addr, 32'hdead_beef, latency);
        check("write hit latency", 1, latency);
        cpu_access(op_read, new_addr, '0, latency);
        check("eviction transactions", 2, mem_log.size());
        check("writeback strobe", 1'b1, mem_log[0].write);
        check("writeback address", old_addr, mem_log[0].addr);
        check("writeback data", 32'hdead_beef, mem_log[0].data);
        check("fill strobe", 1'b0, mem_log[1].write);
        check("fill address", new_addr, mem_log[1].addr);
    endtask

    task automatic allocate_on_write_miss();
        logic [addr_width-1:0] addr;
        logic [addr_width-1:0] other;
        logic [data_width-1:0] old_data;
        int                    latency;

        test_name = "write miss allocate";
        addr      = 16'h0347;
        other     = 16'h0b47;
        old_data  = mem_value(addr);
        cpu_access(op_write, addr, 32'h1234_5678, latency);
        check("allocate reads", 1, mem_log.size());
        check("allocate strobe", 1'b0, mem_log[0].write);
        check("allocate address", addr, mem_log[0].addr);
        cpu_access(op_read, addr, '0, latency);
        check("read after write", 32'h1234_5678, cpu_resp.rdata);
        check("memory before eviction", old_data, mem_value(addr));
        cpu_access(op_read, other, '0, latency);
        check("memory after eviction", 32'h1234_5678, mem_value(addr));
    endtask

    task automatic flush_dirty_lines();
        int latency;

        test_name = "flush";
        for (int i = 0; i < 4; i++) begin
            cpu_access(op_write, 16'h0410 + 16'h0011 * i, 32'hf00d_0000 + i, latency);
        end
        cpu_flush();
        check("flush writes", 4, mem_log.size());
        cpu_flush();
        check("second flush writes", 0, mem_log.size());
        for (int i = 0; i < 4; i++) begin
            cpu_access(op_read, 16'h0410 + 16'h0011 * i, '0, latency);
            check("read after flush latency", 1, latency);
            check("read after flush traffic", 0, mem_log.size());
        end
    endtask

    task automatic random_mix();
        logic [31:0]           op_bit;
        logic [31:0]           offset;
        logic [31:0]           wdata;
        logic [addr_width-1:0] addr;
        int                    latency;

        test_name = "random mix";
        for (int n = 0; n < random_ops; n++) begin
            take_bits(stim_lfsr, 1, op_bit);
            take_bits(stim_lfsr, 6, offset);
            take_bits(stim_lfsr, 32, wdata);
            addr = 16'h2000 + offset[5:0];
            cpu_access(op_bit[0] ? op_write : op_read, addr, wdata, latency);
        end
        cpu_flush();
        for (int a = 0; a < 64; a++) begin
            addr = 16'h2000 + a;
            check("memory after final flush", shadow_value(addr), mem_value(addr));
        end
    endtask

    initial begin
        reset     = 1'b0;
        cpu_valid = 1'b0;
        cpu_req   = '{op: op_none, addr: '0, wdata: '0};
        failures  = 0;
        for (int i = 0; i < 2**index_width; i++) begin
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
            line_tag[i]   = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        expect_reset_state();
        read_miss_then_hit();
        evict_dirty_line();
        allocate_on_write_miss();
        flush_dirty_lines();
        random_mix();

        test_name = "bound assertions";
        check("assertion failures", 0, dut_i.assertions_i.error_count);

        if (failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
